// File: src.f
common/dbg_pkg.sv
jtag/jtag_tap.sv
jtag/jtag_wb_master.sv
rtl/dbg_regs.sv
prbs/prbs_checker.sv
rtl/rx_debug_top.sv
dv/tb_clk_gen.sv
dv/rx_debug_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f \
	--top-module rx_debug_tb -o rx_debug_sim

out=$(./obj_dir/rx_debug_sim)
echo "$out"
echo "$out" | grep -q "^TESTBENCH PASSED$"

// File: dv/rx_debug_tb.sv
`timescale 1ns/100ps

module rx_debug_tb import dbg_pkg::*; ();
	localparam int N_BITS = 200;
	localparam int N_ERRS = 7;

	logic clk;
	logic rst_n;
	logic tck;
	logic tms;
	logic tdi;
	logic trst_n;
	logic tdo;
	logic rx_bit;
	logic rx_valid;
	logic [GAIN_W-1:0] ki;
	logic [GAIN_W-1:0] kp;
	logic err_mask [N_BITS];
	int seed;
	int word_errs;
	int ctrl_errs;
	int gain_errs;
	int other_errs;
	logic [31:0] exp_q[$];
	logic [31:0] got_q[$];
	string name_q[$];

	tb_clk_gen i_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

	rx_debug_top i_dut (
		.clk_i(clk), .rst_n_i(rst_n),
		.tck_i(tck), .tms_i(tms), .tdi_i(tdi), .trst_n_i(trst_n), .tdo_o(tdo),
		.rx_bit_i(rx_bit), .rx_valid_i(rx_valid),
		.ki_o(ki), .kp_o(kp)
	);

	// New bit of x^7 + x^6 + 1 enters at bit 0
	function automatic logic [PRBS_LEN-1:0] prbs7_next(input logic [PRBS_LEN-1:0] s);
		return {s[5:0], s[6] ^ s[5]};
	endfunction

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error: %s got 0x%h, expected 0x%h", name, got, exp);
			word_errs++;
		end
	endtask

	task automatic check_ctrl(input string name, input prbs_mode_e got, input prbs_mode_e exp);
		if (got !== exp) begin
			$display("** Error: %s got 0x%h, expected 0x%h", name, got, exp);
			ctrl_errs++;
		end
	endtask

	task automatic check_gain(input string name, input logic [GAIN_W-1:0] got,
			input logic [GAIN_W-1:0] exp);
		if (got !== exp) begin
			$display("** Error: %s got 0x%h, expected 0x%h", name, got, exp);
			gain_errs++;
		end
	endtask

	task automatic report_counts();
		$display("Errors: word=%0d ctrl=%0d gain=%0d other=%0d",
			word_errs, ctrl_errs, gain_errs, other_errs);
	endtask

	task automatic abort_on_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		other_errs++;
		report_counts();
		$display("TESTBENCH FAILED");
		$finish;
	endtask

	task automatic queue_result(input string name, input logic [31:0] got, input logic [31:0] exp);
		exp_q.push_back(exp);
		name_q.push_back(name);
		got_q.push_back(got);
	endtask

	// Scanned results are compared here as they arrive
	always @(negedge clk) begin
		while (got_q.size() > 0) begin
			check_word(name_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
		end
	end

	// Low for 5 clk then high for 5 clk with tdo sampled late in the low phase
	task automatic jtag_cycle(input logic tms_v, input logic tdi_v, output logic tdo_v);
		@(posedge clk);
		tck <= 1'b0;
		tms <= tms_v;
		tdi <= tdi_v;
		repeat (4) @(posedge clk);
		@(negedge clk);
		tdo_v = tdo;
		@(posedge clk);
		tck <= 1'b1;
		repeat (4) @(posedge clk);
	endtask

	task automatic jtag_move(input logic tms_v);
		logic unused;
		jtag_cycle(tms_v, 1'b0, unused);
	endtask

	// Starts and ends in run_test_idle
	task automatic shift_ir(input logic [IR_LEN-1:0] ir);
		logic unused;
		jtag_move(1'b1);
		jtag_move(1'b1);
		jtag_move(1'b0);
		jtag_move(1'b0);
		for (int i = 0; i < IR_LEN; i++) begin
			jtag_cycle(i == IR_LEN - 1, ir[i], unused);
		end
		jtag_move(1'b1);
		jtag_move(1'b0);
	endtask

	task automatic shift_dr(input logic [63:0] din, input int len, output logic [63:0] dout);
		logic b;
		dout = '0;
		jtag_move(1'b1);
		jtag_move(1'b0);
		jtag_move(1'b0);
		for (int i = 0; i < len; i++) begin
			jtag_cycle(i == len - 1, din[i], b);
			dout[i] = b;
		end
		jtag_move(1'b1);
		jtag_move(1'b0);
	endtask

	task automatic acc_write(input logic [7:0] addr, input logic [31:0] data);
		logic [63:0] unused;
		shift_dr({23'b0, data, addr, 1'b1}, ACC_DR_LEN, unused);
	endtask

	// Second scan captures the result of the first
	task automatic acc_read(input logic [7:0] addr, input logic [31:0] exp, input string name,
			output logic [31:0] rdata);
		logic [63:0] cap;
		shift_dr({23'b0, 32'b0, addr, 1'b0}, ACC_DR_LEN, cap);
		shift_dr({23'b0, 32'b0, addr, 1'b0}, ACC_DR_LEN, cap);
		queue_result(name, cap[40:9], exp);
		queue_result("acc_done", {31'b0, cap[0]}, 32'd1);
		queue_result("acc_addr", {24'b0, cap[8:1]}, 32'd0);
		rdata = cap[40:9];
	endtask

	task automatic drive_stream(input logic [PRBS_LEN-1:0] start, input int n, input logic use_errs);
		logic [PRBS_LEN-1:0] s;
		int gap;
		s = start;
		for (int i = 0; i < n; i++) begin
			s = prbs7_next(s);
			gap = $unsigned($random(seed)) % 3;
			repeat (gap) begin
				@(posedge clk);
				rx_valid <= 1'b0;
			end
			@(posedge clk);
			rx_valid <= 1'b1;
			rx_bit <= s[0] ^ (use_errs && err_mask[i]);
		end
		@(posedge clk);
		rx_valid <= 1'b0;
	endtask

	// Counters must not move while the checker is not running
	task automatic check_hold(input prbs_mode_e mode);
		logic [31:0] rdata;
		acc_write(ADDR_CTRL, 32'(mode));
		drive_stream(7'h5A, 40, 1'b0);
		acc_read(ADDR_TOTAL, N_BITS, "total_cnt", rdata);
		acc_read(ADDR_CORRECT, N_BITS - N_ERRS, "correct_cnt", rdata);
		acc_read(ADDR_CTRL, 32'(mode), "ctrl", rdata);
		check_ctrl("mode", prbs_mode_e'(rdata[1:0]), mode);
	endtask

	task automatic run_scenarios();
		logic [63:0] dout;
		logic [31:0] rdata;
		logic [31:0] wdata;
		logic [PRBS_LEN-1:0] prbs_seed;
		logic [15:0] pattern;
		int placed;
		int pos;

		// IDCODE out of reset and again after TRST
		jtag_move(1'b0);
		shift_dr(64'd0, 32, dout);
		queue_result("idcode", dout[31:0], IDCODE_VALUE);
		shift_ir(INSTR_BYPASS);
		@(posedge clk);
		trst_n <= 1'b0;
		repeat (6) @(posedge clk);
		trst_n <= 1'b1;
		repeat (4) @(posedge clk);
		jtag_move(1'b0);
		shift_dr(64'd0, 32, dout);
		queue_result("idcode after trst", dout[31:0], IDCODE_VALUE);

		shift_ir(INSTR_BYPASS);
		pattern = $random(seed);
		shift_dr({48'b0, pattern}, 17, dout);
		queue_result("bypass tdo", dout[31:0], {15'b0, pattern, 1'b0});

		shift_ir(INSTR_DBG_ACCESS);
		wdata = $random(seed);
		acc_write(ADDR_SCRATCH, wdata);
		acc_read(ADDR_SCRATCH, wdata, "scratch", rdata);
		wdata = $random(seed);
		acc_write(ADDR_GAIN, wdata);
		check_gain("ki_o", ki, wdata[7:0]);
		check_gain("kp_o", kp, wdata[15:8]);
		acc_read(ADDR_GAIN, {16'b0, wdata[15:0]}, "gain", rdata);
		acc_read(8'h7F, 32'd0, "unmapped", rdata);

		// Clean PRBS7 stream
		prbs_seed = 7'($random(seed)) | 7'h01;
		acc_write(ADDR_SEED, 32'(prbs_seed));
		acc_write(ADDR_CTRL, 32'(CHK_RUN));
		drive_stream(prbs_seed, N_BITS, 1'b0);
		acc_read(ADDR_TOTAL, N_BITS, "total_cnt", rdata);
		acc_read(ADDR_CORRECT, N_BITS, "correct_cnt", rdata);

		foreach (err_mask[i]) begin
			err_mask[i] = 1'b0;
		end
		placed = 0;
		while (placed < N_ERRS) begin
			pos = $unsigned($random(seed)) % N_BITS;
			if (!err_mask[pos]) begin
				err_mask[pos] = 1'b1;
				placed++;
			end
		end
		prbs_seed = 7'($random(seed)) | 7'h01;
		acc_write(ADDR_SEED, 32'(prbs_seed));
		drive_stream(prbs_seed, N_BITS, 1'b1);
		acc_read(ADDR_TOTAL, N_BITS, "total_cnt", rdata);
		acc_read(ADDR_CORRECT, N_BITS - N_ERRS, "correct_cnt", rdata);

		check_hold(CHK_SEED);
		check_hold(CHK_OFF);
	endtask

	initial begin
		int t;
		seed = 32'hd057;
		tck = 1'b0;
		tms = 1'b1;
		tdi = 1'b0;
		trst_n = 1'b1;
		rx_bit = 1'b0;
		rx_valid = 1'b0;
		word_errs = 0;
		ctrl_errs = 0;
		gain_errs = 0;
		other_errs = 0;

		t = 0;
		while (rst_n !== 1'b1 && t < 20) begin
			@(posedge clk);
			t++;
		end
		if (rst_n !== 1'b1) begin
			abort_on_timeout("reset release");
		end else begin
			@(posedge clk);
			run_scenarios();

			t = 0;
			while (got_q.size() > 0 && t < 10) begin
				@(posedge clk);
				t++;
			end
			if (got_q.size() > 0) begin
				abort_on_timeout("result comparison");
			end else begin
				report_counts();
				if (word_errs + ctrl_errs + gain_errs + other_errs == 0) begin
					$display("TESTBENCH PASSED");
				end else begin
					$display("TESTBENCH FAILED");
				end
				$finish;
			end
		end
	end

endmodule

// File: dv/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen (
	output logic clk_o,
	output logic rst_n_o
);
	// 8 ns period
	initial begin
		clk_o = 1'b0;
		forever #4 clk_o = ~clk_o;
	end

	initial begin
		rst_n_o = 1'b0;
		repeat (2) @(posedge clk_o);
		rst_n_o <= 1'b1;
	end

endmodule

// File: rtl/rx_debug_top.sv
`timescale 1ns/100ps

module rx_debug_top import dbg_pkg::*; (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic              tck_i,
	input  logic              tms_i,
	input  logic              tdi_i,
	input  logic              trst_n_i,
	output logic              tdo_o,
	input  logic              rx_bit_i,
	input  logic              rx_valid_i,
	output logic [GAIN_W-1:0] ki_o,
	output logic [GAIN_W-1:0] kp_o
);
	logic [ACC_DR_LEN-1:0] acc_cmd;
	logic acc_go;
	logic [REG_DATA_W-1:0] acc_rdata;
	logic acc_done;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [REG_ADDR_W-1:0] wb_adr;
	logic [REG_DATA_W-1:0] wb_dat_w;
	logic [REG_DATA_W-1:0] wb_dat_r;
	logic wb_ack;
	prbs_mode_e chk_mode;
	logic [PRBS_LEN-1:0] chk_seed;
	logic chk_seed_wr;
	logic [REG_DATA_W-1:0] total_cnt;
	logic [REG_DATA_W-1:0] correct_cnt;

	jtag_tap i_tap (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.tck_i(tck_i), .tms_i(tms_i), .tdi_i(tdi_i), .trst_n_i(trst_n_i),
		.acc_rdata_i(acc_rdata), .acc_done_i(acc_done),
		.tdo_o(tdo_o), .acc_cmd_o(acc_cmd), .acc_go_o(acc_go)
	);

	jtag_wb_master i_master (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.acc_cmd_i(acc_cmd), .acc_go_i(acc_go),
		.wb_dat_i(wb_dat_r), .wb_ack_i(wb_ack),
		.acc_rdata_o(acc_rdata), .acc_done_o(acc_done),
		.wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we),
		.wb_adr_o(wb_adr), .wb_dat_o(wb_dat_w)
	);

	dbg_regs i_regs (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
		.wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w),
		.total_cnt_i(total_cnt), .correct_cnt_i(correct_cnt),
		.wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack),
		.mode_o(chk_mode), .seed_o(chk_seed), .seed_wr_o(chk_seed_wr),
		.ki_o(ki_o), .kp_o(kp_o)
	);

	prbs_checker i_checker (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.mode_i(chk_mode), .seed_i(chk_seed), .seed_wr_i(chk_seed_wr),
		.rx_bit_i(rx_bit_i), .rx_valid_i(rx_valid_i),
		.total_cnt_o(total_cnt), .correct_cnt_o(correct_cnt)
	);

endmodule

// File: prbs/prbs_checker.sv
`timescale 1ns/100ps

module prbs_checker import dbg_pkg::*; (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  prbs_mode_e            mode_i,
	input  logic [PRBS_LEN-1:0]   seed_i,
	input  logic                  seed_wr_i,
	input  logic                  rx_bit_i,
	input  logic                  rx_valid_i,
	output logic [REG_DATA_W-1:0] total_cnt_o,
	output logic [REG_DATA_W-1:0] correct_cnt_o
);
	logic [PRBS_LEN-1:0] lfsr_q;
	logic pred_bit;
	logic check;
	logic match;

	// Taps 7 and 6 of the polynomial
	assign pred_bit = lfsr_q[PRBS_LEN-1] ^ lfsr_q[PRBS_LEN-2];
	assign check    = (mode_i == CHK_RUN) && rx_valid_i;
	assign match    = (rx_bit_i == pred_bit);

	// Self-feeding LFSR so a bit error does not corrupt later predictions
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			lfsr_q <= '1;
		end else if (seed_wr_i) begin
			lfsr_q <= seed_i;
		end else if (check) begin
			lfsr_q <= {lfsr_q[PRBS_LEN-2:0], pred_bit};
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			total_cnt_o   <= '0;
			correct_cnt_o <= '0;
		end else if (seed_wr_i) begin
			total_cnt_o   <= '0;
			correct_cnt_o <= '0;
		end else if (check) begin
			total_cnt_o <= total_cnt_o + 1'b1;
			if (match) begin
				correct_cnt_o <= correct_cnt_o + 1'b1;
			end
		end
	end

	correct_le_total: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		correct_cnt_o <= total_cnt_o);

endmodule

// File: rtl/dbg_regs.sv
`timescale 1ns/100ps

module dbg_regs import dbg_pkg::*; (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic                  wb_cyc_i,
	input  logic                  wb_stb_i,
	input  logic                  wb_we_i,
	input  logic [REG_ADDR_W-1:0] wb_adr_i,
	input  logic [REG_DATA_W-1:0] wb_dat_i,
	input  logic [REG_DATA_W-1:0] total_cnt_i,
	input  logic [REG_DATA_W-1:0] correct_cnt_i,
	output logic [REG_DATA_W-1:0] wb_dat_o,
	output logic                  wb_ack_o,
	output prbs_mode_e            mode_o,
	output logic [PRBS_LEN-1:0]   seed_o,
	output logic                  seed_wr_o,
	output logic [GAIN_W-1:0]     ki_o,
	output logic [GAIN_W-1:0]     kp_o
);
	logic access;
	logic [REG_DATA_W-1:0] scratch_q;

	// First cycle of stb only, ack ends the transfer
	assign access = wb_cyc_i && wb_stb_i && !wb_ack_o;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			wb_ack_o  <= 1'b0;
			mode_o    <= CHK_OFF;
			seed_o    <= '0;
			seed_wr_o <= 1'b0;
			ki_o      <= '0;
			kp_o      <= '0;
			scratch_q <= '0;
		end else begin
			wb_ack_o  <= access;
			seed_wr_o <= 1'b0;
			if (access && wb_we_i) begin
				case (wb_adr_i)
					ADDR_CTRL: begin
						mode_o <= prbs_mode_e'(wb_dat_i[1:0]);
					end
					ADDR_SEED: begin
						seed_o    <= wb_dat_i[PRBS_LEN-1:0];
						seed_wr_o <= 1'b1;
					end
					ADDR_GAIN: begin
						ki_o <= wb_dat_i[GAIN_W-1:0];
						kp_o <= wb_dat_i[2*GAIN_W-1:GAIN_W];
					end
					ADDR_SCRATCH: begin
						scratch_q <= wb_dat_i;
					end
					default: ;
				endcase
			end
		end
	end

	// Counters are sampled live, so a read sees them at the ack cycle
	always_comb begin
		case (wb_adr_i)
			ADDR_CTRL:    wb_dat_o = REG_DATA_W'(mode_o);
			ADDR_SEED:    wb_dat_o = REG_DATA_W'(seed_o);
			ADDR_GAIN:    wb_dat_o = REG_DATA_W'({kp_o, ki_o});
			ADDR_TOTAL:   wb_dat_o = total_cnt_i;
			ADDR_CORRECT: wb_dat_o = correct_cnt_i;
			ADDR_SCRATCH: wb_dat_o = scratch_q;
			default:      wb_dat_o = '0;
		endcase
	end

	ack_with_stb: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wb_ack_o |-> wb_stb_i);

endmodule

// File: jtag/jtag_wb_master.sv
`timescale 1ns/100ps

module jtag_wb_master import dbg_pkg::*; (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic [ACC_DR_LEN-1:0] acc_cmd_i,
	input  logic                  acc_go_i,
	input  logic [REG_DATA_W-1:0] wb_dat_i,
	input  logic                  wb_ack_i,
	output logic [REG_DATA_W-1:0] acc_rdata_o,
	output logic                  acc_done_o,
	output logic                  wb_cyc_o,
	output logic                  wb_stb_o,
	output logic                  wb_we_o,
	output logic [REG_ADDR_W-1:0] wb_adr_o,
	output logic [REG_DATA_W-1:0] wb_dat_o
);
	logic start;

	// New commands are dropped while a cycle is open
	assign start = acc_go_i && !wb_cyc_o;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			wb_cyc_o   <= 1'b0;
			wb_stb_o   <= 1'b0;
			acc_done_o <= 1'b1;
		end else if (wb_cyc_o) begin
			if (wb_ack_i) begin
				wb_cyc_o   <= 1'b0;
				wb_stb_o   <= 1'b0;
				acc_done_o <= 1'b1;
			end
		end else if (start) begin
			wb_cyc_o   <= 1'b1;
			wb_stb_o   <= 1'b1;
			acc_done_o <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (start) begin
			wb_we_o  <= acc_cmd_i[ACC_WE_BIT];
			wb_adr_o <= acc_cmd_i[ACC_ADR_LSB +: REG_ADDR_W];
			wb_dat_o <= acc_cmd_i[ACC_DAT_LSB +: REG_DATA_W];
		end
	end

	// Writes leave the last read word in place
	always_ff @(posedge clk_i) begin
		if (wb_cyc_o && wb_ack_i && !wb_we_o) begin
			acc_rdata_o <= wb_dat_i;
		end
	end

	stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wb_stb_o |-> wb_cyc_o);

	req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wb_stb_o && !wb_ack_i |=> $stable(wb_adr_o) && $stable(wb_dat_o) && $stable(wb_we_o));

endmodule

// File: jtag/jtag_tap.sv
`timescale 1ns/100ps

module jtag_tap import dbg_pkg::*; (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic                  tck_i,
	input  logic                  tms_i,
	input  logic                  tdi_i,
	input  logic                  trst_n_i,
	input  logic [REG_DATA_W-1:0] acc_rdata_i,
	input  logic                  acc_done_i,
	output logic                  tdo_o,
	output logic [ACC_DR_LEN-1:0] acc_cmd_o,
	output logic                  acc_go_o
);
	logic [1:0] tck_sync;
	logic [1:0] tms_sync;
	logic [1:0] tdi_sync;
	logic [1:0] trst_sync;
	logic tck_prev;
	logic tck_rise;
	logic tck_fall;
	logic tap_rst;
	tap_state_e state_q;
	tap_state_e state_d;
	logic [IR_LEN-1:0] ir_sr;
	logic [IR_LEN-1:0] ir_q;
	logic [31:0] idcode_sr;
	logic bypass_sr;
	logic [ACC_DR_LEN-1:0] acc_sr;
	logic dr_tdo;

	// Pins are oversampled by clk
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			tck_sync  <= '0;
			tms_sync  <= '1;
			tdi_sync  <= '0;
			trst_sync <= '1;
			tck_prev  <= 1'b0;
		end else begin
			tck_sync  <= {tck_sync[0], tck_i};
			tms_sync  <= {tms_sync[0], tms_i};
			tdi_sync  <= {tdi_sync[0], tdi_i};
			trst_sync <= {trst_sync[0], trst_n_i};
			tck_prev  <= tck_sync[1];
		end
	end

	assign tck_rise = tck_sync[1] & ~tck_prev;
	assign tck_fall = ~tck_sync[1] & tck_prev;
	assign tap_rst  = !rst_n_i || !trst_sync[1];

	always_comb begin
		case (state_q)
			test_logic_reset: state_d = tms_sync[1] ? test_logic_reset : run_test_idle;
			run_test_idle:    state_d = tms_sync[1] ? select_dr : run_test_idle;
			select_dr:        state_d = tms_sync[1] ? select_ir : capture_dr;
			capture_dr:       state_d = tms_sync[1] ? exit1_dr : shift_dr;
			shift_dr:         state_d = tms_sync[1] ? exit1_dr : shift_dr;
			exit1_dr:         state_d = tms_sync[1] ? update_dr : pause_dr;
			pause_dr:         state_d = tms_sync[1] ? exit2_dr : pause_dr;
			exit2_dr:         state_d = tms_sync[1] ? update_dr : shift_dr;
			update_dr:        state_d = tms_sync[1] ? select_dr : run_test_idle;
			select_ir:        state_d = tms_sync[1] ? test_logic_reset : capture_ir;
			capture_ir:       state_d = tms_sync[1] ? exit1_ir : shift_ir;
			shift_ir:         state_d = tms_sync[1] ? exit1_ir : shift_ir;
			exit1_ir:         state_d = tms_sync[1] ? update_ir : pause_ir;
			pause_ir:         state_d = tms_sync[1] ? exit2_ir : pause_ir;
			exit2_ir:         state_d = tms_sync[1] ? update_ir : shift_ir;
			default:          state_d = tms_sync[1] ? select_dr : run_test_idle;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (tap_rst) begin
			state_q <= test_logic_reset;
			ir_q    <= INSTR_IDCODE;
		end else if (tck_rise) begin
			state_q <= state_d;
			if (state_q == test_logic_reset) begin
				ir_q <= INSTR_IDCODE;
			end else if (state_d == update_ir) begin
				ir_q <= ir_sr;
			end
		end
	end

	// IR capture loads the mandatory 01 pattern
	always_ff @(posedge clk_i) begin
		if (tck_rise && state_q == capture_ir) begin
			ir_sr <= IR_LEN'(1);
		end else if (tck_rise && state_q == shift_ir) begin
			ir_sr <= {tdi_sync[1], ir_sr[IR_LEN-1:1]};
		end
	end

	always_ff @(posedge clk_i) begin
		if (tck_rise && state_q == capture_dr) begin
			idcode_sr <= IDCODE_VALUE;
			bypass_sr <= 1'b0;
			acc_sr    <= {acc_rdata_i, {REG_ADDR_W{1'b0}}, acc_done_i};
		end else if (tck_rise && state_q == shift_dr) begin
			case (ir_q)
				INSTR_IDCODE:     idcode_sr <= {tdi_sync[1], idcode_sr[31:1]};
				INSTR_DBG_ACCESS: acc_sr <= {tdi_sync[1], acc_sr[ACC_DR_LEN-1:1]};
				default:          bypass_sr <= tdi_sync[1];
			endcase
		end
	end

	always_comb begin
		case (ir_q)
			INSTR_IDCODE:     dr_tdo = idcode_sr[0];
			INSTR_DBG_ACCESS: dr_tdo = acc_sr[0];
			default:          dr_tdo = bypass_sr;
		endcase
	end

	// TDO moves on the falling edge only
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			tdo_o <= 1'b0;
		end else if (tck_fall) begin
			if (state_q == shift_dr) begin
				tdo_o <= dr_tdo;
			end else if (state_q == shift_ir) begin
				tdo_o <= ir_sr[0];
			end else begin
				tdo_o <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (tap_rst) begin
			acc_go_o <= 1'b0;
		end else begin
			acc_go_o <= tck_rise && state_d == update_dr && ir_q == INSTR_DBG_ACCESS;
		end
	end

	assign acc_cmd_o = acc_sr;

	go_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		acc_go_o |=> !acc_go_o);

endmodule

// File: common/dbg_pkg.sv
package dbg_pkg;

	// IEEE 1149.1 controller states, classic 4-bit encoding
	typedef enum logic [3:0] {
		exit2_dr         = 4'h0,
		exit1_dr         = 4'h1,
		shift_dr         = 4'h2,
		pause_dr         = 4'h3,
		select_ir        = 4'h4,
		update_dr        = 4'h5,
		capture_dr       = 4'h6,
		select_dr        = 4'h7,
		exit2_ir         = 4'h8,
		exit1_ir         = 4'h9,
		shift_ir         = 4'hA,
		pause_ir         = 4'hB,
		run_test_idle    = 4'hC,
		update_ir        = 4'hD,
		capture_ir       = 4'hE,
		test_logic_reset = 4'hF
	} tap_state_e;

	// Unlisted opcodes fall back to bypass
	typedef enum logic [3:0] {
		INSTR_IDCODE     = 4'd1,
		INSTR_DBG_ACCESS = 4'd8,
		INSTR_BYPASS     = 4'd15
	} jtag_instr_e;

	typedef enum logic [1:0] {
		CHK_OFF  = 2'd0,
		CHK_SEED = 2'd1,
		CHK_RUN  = 2'd2
	} prbs_mode_e;

	localparam int IR_LEN       = 4;
	localparam logic [31:0] IDCODE_VALUE = 32'h1D0C_0A5B;

	// Access DR: {data, addr, we}
	localparam int ACC_DR_LEN   = 41;
	localparam int ACC_WE_BIT   = 0;
	localparam int ACC_ADR_LSB  = 1;
	localparam int ACC_DAT_LSB  = 9;

	localparam int REG_ADDR_W   = 8;
	localparam int REG_DATA_W   = 32;
	localparam int GAIN_W       = 8;

	localparam logic [REG_ADDR_W-1:0] ADDR_CTRL    = 8'd0;
	localparam logic [REG_ADDR_W-1:0] ADDR_SEED    = 8'd1;
	localparam logic [REG_ADDR_W-1:0] ADDR_GAIN    = 8'd2;
	localparam logic [REG_ADDR_W-1:0] ADDR_TOTAL   = 8'd3;
	localparam logic [REG_ADDR_W-1:0] ADDR_CORRECT = 8'd4;
	localparam logic [REG_ADDR_W-1:0] ADDR_SCRATCH = 8'd5;

	// x^7 + x^6 + 1
	localparam int PRBS_LEN     = 7;

endpackage
